/* design/rob_params.svh */
// reorder buffer sizing
// lane counts, writeback ports, depth and result width
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// micro-ops accepted from dispatch per cycle
`define NUM_DP_UOP 2

// micro-ops handed to the retire unit per cycle
`define NUM_RT_UOP 2

// generic result writeback ports
`define NUM_WB 2

// entries, must stay a power of two so pointers wrap on their own
`define ROB_DEPTH 8
`define ROB_DEPTH_WIDTH 3

// result data carried per entry
`define ROB_DATA_WIDTH 32

`endif

/* design/rob_pkg.sv */
// reorder buffer types
// payloads for dispatch, writeback, trap, retire and the dispatch view
`include "rob_params.svh"

package rob_pkg;

  // what dispatch hands over with each micro-op
  typedef struct packed {
    logic [4:0] w_index;
    logic       w_type;
    logic [7:0] vector_csr;
  } rob_uop_t;

  // one result returned by an execution unit
  typedef struct packed {
    logic [`ROB_DEPTH_WIDTH-1:0] rob_entry;
    logic                        w_valid;
    logic [`ROB_DATA_WIDTH-1:0]  w_data;
    logic                        vsaturate;
  } rob_wb_t;

  typedef struct packed {
    logic [`ROB_DEPTH_WIDTH-1:0] trap_entry;
  } rob_trap_t;

  // one retiring micro-op, uop fields plus its result
  typedef struct packed {
    logic                       w_valid;
    logic [4:0]                 w_index;
    logic                       w_type;
    logic [`ROB_DATA_WIDTH-1:0] w_data;
    logic [7:0]                 vector_csr;
    logic                       vxsaturate;
    logic                       trap_flag;
  } rob_rt_t;

  // entry as seen by dispatch for operand forwarding
  typedef struct packed {
    logic                       valid;
    logic                       w_valid;
    logic [4:0]                 w_index;
    logic                       w_type;
    logic [`ROB_DATA_WIDTH-1:0] w_data;
    logic [7:0]                 vector_csr;
  } rob_view_t;

endpackage

/* design/multi_fifo.sv */
// multi-port circular buffer
// pushes several lanes and pops an oldest-first prefix per cycle,
// with raw storage and pointers visible to the surrounding logic
module multi_fifo #(
  parameter type T        = rob_pkg::rob_uop_t,
  parameter int  NUM_PUSH = 2,
  parameter int  NUM_POP  = 2,
  parameter int  DEPTH    = 8,
  localparam int AW       = $clog2(DEPTH),
  localparam int CW       = $clog2(DEPTH + 1)
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [NUM_PUSH-1:0] push,
  input  T     [NUM_PUSH-1:0] datain,
  input  logic [NUM_POP-1:0]  pop,
  input  logic                clear,
  output T     [NUM_POP-1:0]  dataout,
  output T     [DEPTH-1:0]    fifo_data,
  output logic [AW-1:0]       wptr,
  output logic [AW-1:0]       rptr,
  output logic [CW-1:0]       count
);

  T     [DEPTH-1:0] mem;
  logic [AW-1:0]    push_slot [NUM_PUSH];
  logic [CW-1:0]    push_num;
  logic [CW-1:0]    pop_num;

  // lanes that are not pushing take no slot, so later lanes move down
  always_comb begin
    push_num = '0;
    for (int i = 0; i < NUM_PUSH; i++) begin
      push_slot[i] = wptr + push_num[AW-1:0];
      push_num     = push_num + CW'(push[i]);
    end
  end

  // pop is a prefix, its population is the read advance
  always_comb begin
    pop_num = '0;
    for (int i = 0; i < NUM_POP; i++) begin
      pop_num = pop_num + CW'(pop[i]);
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_PUSH; i++) begin
      if (push[i]) begin
        mem[push_slot[i]] <= datain[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else if (clear) begin
      // clear wins over any push or pop in the same cycle
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      wptr  <= wptr + push_num[AW-1:0];
      rptr  <= rptr + pop_num[AW-1:0];
      count <= count + push_num - pop_num;
    end
  end

  // oldest entries first
  for (genvar i = 0; i < NUM_POP; i++) begin : gen_dataout
    assign dataout[i] = mem[rptr + AW'(i)];
  end

  assign fifo_data = mem;

endmodule

/* design/rob_result_mem.sv */
// result storage of the reorder buffer
// captures writeback results and builds retire records and the dispatch view
`include "rob_params.svh"

module rob_result_mem (
  input  logic                                   clk,
  input  logic               [`NUM_WB-1:0]           wb_valid,
  input  rob_pkg::rob_wb_t   [`NUM_WB-1:0]           wb,
  input  logic               [`ROB_DEPTH_WIDTH-1:0]  rptr,
  input  logic               [`ROB_DEPTH_WIDTH:0]    count,
  input  logic               [`ROB_DEPTH-1:0]        done,
  input  rob_pkg::rob_uop_t  [`ROB_DEPTH-1:0]        uop_data,
  output rob_pkg::rob_rt_t   [`NUM_RT_UOP-1:0]       rt,
  output rob_pkg::rob_view_t [`ROB_DEPTH-1:0]        rob_view
);

  localparam int AW = `ROB_DEPTH_WIDTH;
  localparam int CW = `ROB_DEPTH_WIDTH + 1;

  logic [`ROB_DEPTH-1:0]                      res_w_valid;
  logic [`ROB_DEPTH-1:0][`ROB_DATA_WIDTH-1:0] res_data;
  logic [`ROB_DEPTH-1:0]                      res_sat;
  logic [AW-1:0]                              view_slot [`ROB_DEPTH];
  logic [AW-1:0]                              rt_slot   [`NUM_RT_UOP];

  // ports never share an entry in one cycle
  always_ff @(posedge clk) begin
    for (int k = 0; k < `NUM_WB; k++) begin
      if (wb_valid[k]) begin
        res_w_valid[wb[k].rob_entry] <= wb[k].w_valid;
        res_data[wb[k].rob_entry]    <= wb[k].w_data;
        res_sat[wb[k].rob_entry]     <= wb[k].vsaturate;
      end
    end
  end

  // view position i is the i-th oldest micro-op
  for (genvar i = 0; i < `ROB_DEPTH; i++) begin : gen_view
    assign view_slot[i]           = rptr + AW'(i);
    assign rob_view[i].valid      = count > CW'(i);
    assign rob_view[i].w_valid    = res_w_valid[view_slot[i]] & done[view_slot[i]];
    assign rob_view[i].w_index    = uop_data[view_slot[i]].w_index;
    assign rob_view[i].w_type     = uop_data[view_slot[i]].w_type;
    assign rob_view[i].w_data     = res_data[view_slot[i]];
    assign rob_view[i].vector_csr = uop_data[view_slot[i]].vector_csr;
  end

  for (genvar i = 0; i < `NUM_RT_UOP; i++) begin : gen_rt
    assign rt_slot[i]          = rptr + AW'(i);
    assign rt[i].w_valid       = res_w_valid[rt_slot[i]] & done[rt_slot[i]];
    assign rt[i].w_index       = uop_data[rt_slot[i]].w_index;
    assign rt[i].w_type        = uop_data[rt_slot[i]].w_type;
    assign rt[i].w_data        = res_data[rt_slot[i]];
    assign rt[i].vector_csr    = uop_data[rt_slot[i]].vector_csr;
    assign rt[i].vxsaturate    = res_sat[rt_slot[i]];
    // filled in at the top from the trap flags
    assign rt[i].trap_flag     = 1'b0;
  end

endmodule

/* design/rob_ctrl.sv */
// reorder buffer control
// tracks done and trap flags, qualifies in-order retire and raises flush
`include "rob_params.svh"

module rob_ctrl (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic              [`NUM_WB-1:0]           wb_valid,
  input  rob_pkg::rob_wb_t  [`NUM_WB-1:0]           wb,
  input  logic                                  trap_valid,
  input  rob_pkg::rob_trap_t                    trap,
  input  logic              [`ROB_DEPTH_WIDTH-1:0]  rptr,
  input  logic              [`ROB_DEPTH_WIDTH:0]    count,
  input  logic              [`NUM_RT_UOP-1:0]       rt_ready,
  output logic              [`ROB_DEPTH-1:0]        done,
  output logic              [`NUM_RT_UOP-1:0]       rt_valid,
  output logic              [`NUM_RT_UOP-1:0]       rt_trap,
  output logic                                  flush
);

  localparam int AW = `ROB_DEPTH_WIDTH;
  localparam int CW = `ROB_DEPTH_WIDTH + 1;

  logic [`ROB_DEPTH-1:0]   trap_flag;
  logic [AW-1:0]           rt_slot [`NUM_RT_UOP];
  logic [`NUM_RT_UOP-1:0]  occupied;

  for (genvar i = 0; i < `NUM_RT_UOP; i++) begin : gen_retire
    assign rt_slot[i]  = rptr + AW'(i);
    assign occupied[i] = count > CW'(i);
    assign rt_trap[i]  = trap_flag[rt_slot[i]];

    if (i == 0) begin : gen_head
      assign rt_valid[i] = rt_ready[i] & occupied[i] & done[rt_slot[i]];
    end else begin : gen_chain
      // a trapped older micro-op keeps younger lanes back for the flush
      assign rt_valid[i] = rt_ready[i] & occupied[i] & done[rt_slot[i]] &
                           rt_valid[i-1] & ~trap_flag[rt_slot[i-1]];
    end
  end

  // rt_valid already carries ready, so valid alone means retired
  assign flush = |(rt_valid & rt_trap);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done      <= '0;
      trap_flag <= '0;
    end else if (flush) begin
      done      <= '0;
      trap_flag <= '0;
    end else begin
      // retired entries free up for the next dispatch
      for (int k = 0; k < `NUM_RT_UOP; k++) begin
        if (rt_valid[k]) begin
          done[rt_slot[k]]      <= 1'b0;
          trap_flag[rt_slot[k]] <= 1'b0;
        end
      end

      for (int k = 0; k < `NUM_WB; k++) begin
        if (wb_valid[k]) begin
          done[wb[k].rob_entry] <= 1'b1;
        end
      end

      if (trap_valid) begin
        trap_flag[trap.trap_entry] <= 1'b1;
      end
    end
  end

endmodule

/* design/rob_top.sv */
// reorder buffer of the vector backend
// in-order dispatch and retire around out-of-order result writeback
`include "rob_params.svh"

module rob_top (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic               [`NUM_DP_UOP-1:0]       uop_valid,
  input  rob_pkg::rob_uop_t  [`NUM_DP_UOP-1:0]       uop,
  output logic               [`NUM_DP_UOP-1:0]       uop_ready,
  output logic               [`ROB_DEPTH_WIDTH-1:0]  uop_index,
  input  logic               [`NUM_WB-1:0]           wb_valid,
  input  rob_pkg::rob_wb_t   [`NUM_WB-1:0]           wb,
  input  logic                                   trap_valid,
  input  rob_pkg::rob_trap_t                     trap,
  output logic               [`NUM_RT_UOP-1:0]       rt_valid,
  output rob_pkg::rob_rt_t   [`NUM_RT_UOP-1:0]       rt,
  input  logic               [`NUM_RT_UOP-1:0]       rt_ready,
  output rob_pkg::rob_view_t [`ROB_DEPTH-1:0]        rob_view
);

  import rob_pkg::*;

  localparam int CW = `ROB_DEPTH_WIDTH + 1;

  rob_uop_t [`ROB_DEPTH-1:0]       uop_data;
  rob_rt_t  [`NUM_RT_UOP-1:0]      rt_res;
  logic     [`ROB_DEPTH_WIDTH-1:0] wptr;
  logic     [`ROB_DEPTH_WIDTH-1:0] rptr;
  logic     [CW-1:0]               count;
  logic     [CW-1:0]               free_num;
  logic     [`ROB_DEPTH-1:0]       done;
  logic     [`NUM_RT_UOP-1:0]      rt_trap;
  logic                            flush;

  // lane i needs room for itself and every lane below it
  assign free_num = CW'(`ROB_DEPTH) - count;
  for (genvar i = 0; i < `NUM_DP_UOP; i++) begin : gen_ready
    assign uop_ready[i] = free_num > CW'(i);
  end

  assign uop_index = wptr;

  multi_fifo #(
    .T        (rob_uop_t),
    .NUM_PUSH (`NUM_DP_UOP),
    .NUM_POP  (`NUM_RT_UOP),
    .DEPTH    (`ROB_DEPTH)
  ) u_uop_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (uop_valid & uop_ready),
    .datain    (uop),
    .pop       (rt_valid & rt_ready),
    .clear     (flush),
    .dataout   (),
    .fifo_data (uop_data),
    .wptr      (wptr),
    .rptr      (rptr),
    .count     (count)
  );

  rob_result_mem u_result_mem (
    .clk      (clk),
    .wb_valid (wb_valid),
    .wb       (wb),
    .rptr     (rptr),
    .count    (count),
    .done     (done),
    .uop_data (uop_data),
    .rt       (rt_res),
    .rob_view (rob_view)
  );

  rob_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_valid   (wb_valid),
    .wb         (wb),
    .trap_valid (trap_valid),
    .trap       (trap),
    .rptr       (rptr),
    .count      (count),
    .rt_ready   (rt_ready),
    .done       (done),
    .rt_valid   (rt_valid),
    .rt_trap    (rt_trap),
    .flush      (flush)
  );

  always_comb begin
    rt = rt_res;
    for (int i = 0; i < `NUM_RT_UOP; i++) begin
      rt[i].trap_flag = rt_trap[i];
    end
  end

endmodule

/* test/tb_rob.sv */
// testbench for the reorder buffer
// random dispatch, writeback, traps and retire checked against a reference model
`include "rob_params.svh"

module tb_rob;
  import rob_pkg::*;

  localparam int DEPTH = `ROB_DEPTH;
  localparam int NUM_CYCLES = 1000;
  localparam int MAX_CYCLES = 2000;

  logic clk;
  logic rst_n;
  logic [`NUM_DP_UOP-1:0] uop_valid;
  rob_uop_t [`NUM_DP_UOP-1:0] uop;
  logic [`NUM_DP_UOP-1:0] uop_ready;
  logic [`ROB_DEPTH_WIDTH-1:0] uop_index;
  logic [`NUM_WB-1:0] wb_valid;
  rob_wb_t [`NUM_WB-1:0] wb;
  logic trap_valid;
  rob_trap_t trap;
  logic [`NUM_RT_UOP-1:0] rt_valid;
  rob_rt_t [`NUM_RT_UOP-1:0] rt;
  logic [`NUM_RT_UOP-1:0] rt_ready;
  rob_view_t [`ROB_DEPTH-1:0] rob_view;

  // reference model state per buffer entry
  rob_uop_t mu [DEPTH];
  bit md [DEPTH];
  bit mt [DEPTH];
  bit mwv [DEPTH];
  bit msat [DEPTH];
  logic [`ROB_DATA_WIDTH-1:0] mdata [DEPTH];
  int mc, mr, mw;
  int cycles = 0;
  integer seed = 32'h9e76_999c;

  rob_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
      else report_failure($sformatf("Error: %s got %h expected %h", name, got, exp));
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      report_failure("timeout: the run went past its cycle limit");
    end
  end

  // check outputs mid-cycle, then step the model across the coming edge
  always @(negedge clk) begin
    logic [`NUM_RT_UOP-1:0] ev;
    logic [`NUM_DP_UOP-1:0] er;
    rob_rt_t xr;
    int s, npush, npop;
    bit fl;
    if (rst_n) begin
      for (int i = 0; i < `NUM_DP_UOP; i++) er[i] = (DEPTH - mc) > i;
      ev[0] = rt_ready[0] && mc > 0 && md[mr];
      ev[1] = rt_ready[1] && mc > 1 && md[(mr + 1) % DEPTH] && ev[0] && !mt[mr];
      check_value("uop_ready", 64'(uop_ready), 64'(er));
      check_value("uop_index", 64'(uop_index), 64'(mw));
      check_value("rt_valid", 64'(rt_valid), 64'(ev));
      for (int i = 0; i < `NUM_RT_UOP; i++) begin
        s = (mr + i) % DEPTH;
        if (ev[i]) begin
          xr = '{mwv[s], mu[s].w_index, mu[s].w_type, mdata[s], mu[s].vector_csr, msat[s], mt[s]};
          check_value($sformatf("rt[%0d]", i), 64'(rt[i]), 64'(xr));
        end
      end
      for (int i = 0; i < DEPTH; i++) begin
        s = (mr + i) % DEPTH;
        check_value($sformatf("rob_view[%0d].valid", i), 64'(rob_view[i].valid), 64'(i < mc));
        if (i < mc) begin
          check_value($sformatf("rob_view[%0d].fields", i),
            64'({rob_view[i].w_valid, rob_view[i].w_index, rob_view[i].w_type,
                 rob_view[i].vector_csr}),
            64'({mwv[s] & md[s], mu[s].w_index, mu[s].w_type, mu[s].vector_csr}));
          if (md[s]) begin
            check_value($sformatf("rob_view[%0d].w_data", i), 64'(rob_view[i].w_data),
              64'(mdata[s]));
          end
        end
      end
      fl = (ev[0] && mt[mr]) || (ev[1] && mt[(mr + 1) % DEPTH]);
      // result storage is written even when a flush clears the flags
      for (int k = 0; k < `NUM_WB; k++) begin
        if (wb_valid[k]) begin
          mwv[wb[k].rob_entry] = wb[k].w_valid;
          mdata[wb[k].rob_entry] = wb[k].w_data;
          msat[wb[k].rob_entry] = wb[k].vsaturate;
        end
      end
      if (fl) begin
        for (int i = 0; i < DEPTH; i++) begin
          md[i] = 1'b0;
          mt[i] = 1'b0;
        end
        mc = 0;
        mr = 0;
        mw = 0;
      end else begin
        npop = 0;
        npush = 0;
        for (int i = 0; i < `NUM_RT_UOP; i++) begin
          if (ev[i]) begin
            md[(mr + i) % DEPTH] = 1'b0;
            mt[(mr + i) % DEPTH] = 1'b0;
            npop++;
          end
        end
        for (int i = 0; i < `NUM_DP_UOP; i++) begin
          if (uop_valid[i] && er[i]) begin
            mu[mw] = uop[i];
            mw = (mw + 1) % DEPTH;
            npush++;
          end
        end
        for (int k = 0; k < `NUM_WB; k++) begin
          if (wb_valid[k]) md[wb[k].rob_entry] = 1'b1;
        end
        if (trap_valid) mt[trap.trap_entry] = 1'b1;
        mr = (mr + npop) % DEPTH;
        mc = mc + npush - npop;
      end
    end
  end

  initial begin
    rob_uop_t [`NUM_DP_UOP-1:0] u;
    rob_wb_t [`NUM_WB-1:0] w;
    logic [`NUM_WB-1:0] wv;
    logic [31:0] r;
    int s, phase;
    rst_n <= 1'b0;
    uop_valid <= '0;
    uop <= '0;
    wb_valid <= '0;
    wb <= '0;
    trap_valid <= 1'b0;
    trap <= '0;
    rt_ready <= '0;
    mc = 0;
    mr = 0;
    mw = 0;
    for (int i = 0; i < DEPTH; i++) begin
      md[i] = 1'b0;
      mt[i] = 1'b0;
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    for (int n = 0; n < NUM_CYCLES; n++) begin
      @(posedge clk);
      // retire stalled to fill the buffer, then random, then always ready
      phase = (n / 40) % 3;
      r = $random(seed);
      uop_valid <= r[1:0];
      rt_ready <= (phase == 0) ? 2'b00 : (phase == 1) ? r[3:2] : 2'b11;
      for (int i = 0; i < `NUM_DP_UOP; i++) begin
        r = $random(seed);
        u[i] = '{r[4:0], r[5], r[13:6]};
      end
      uop <= u;
      // results only for occupied entries still waiting and never twice for one entry
      wv = '0;
      for (int k = 0; k < `NUM_WB; k++) begin
        r = $random(seed);
        s = (mr + int'(r[2:0])) % DEPTH;
        w[k] = '{3'(s), r[3], $random(seed), r[4]};
        if (mc > 0 && int'(r[2:0]) < mc && !md[s] && r[6:5] != 2'b00 &&
            !(k == 1 && wv[0] && w[0].rob_entry == 3'(s))) wv[k] = 1'b1;
      end
      wb <= w;
      wb_valid <= wv;
      r = $random(seed);
      s = (mr + int'(r[2:0])) % DEPTH;
      trap <= '{3'(s)};
      trap_valid <= int'(r[2:0]) < mc && !md[s] && r[6:3] == 4'b0000;
    end
    repeat (2) @(posedge clk);
    $display("Finished with no errors");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+design
design/rob_pkg.sv
design/multi_fifo.sv
design/rob_result_mem.sv
design/rob_ctrl.sv
design/rob_top.sv
test/tb_rob.sv

/* run.sh */
#!/bin/sh
# compile and run the reorder buffer testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
  -f vlog.f \
  --top-module tb_rob \
  -o sim_rob
./obj_dir/sim_rob
